//--- fetch_consts.svh
`ifndef FETCH_CONSTS_SVH
`define FETCH_CONSTS_SVH

// datapath widths
`define FETCH_XLEN        64
`define FETCH_INST_W      32

// cache geometry
`define FETCH_LINE_BYTES  16
`define FETCH_LINE_BEATS  2
`define FETCH_LINES       16
`define FETCH_OFS_W       ($clog2(`FETCH_LINE_BYTES))   // byte offset in a line
`define FETCH_IDX_W       ($clog2(`FETCH_LINES))
`define FETCH_TAG_W       (`FETCH_XLEN - `FETCH_IDX_W - `FETCH_OFS_W)

`define FETCH_RESET_PC    64'h0000_0000_8000_0000

// AXI read channel constants
`define FETCH_AXI_ID      4'd1
`define FETCH_AXI_SIZE    3'd3      // 8 bytes per beat
`define FETCH_AXI_INCR    2'b01
`define FETCH_AXI_OKAY    2'b00

`define FETCH_NOP         32'h0000_0013   // addi x0, x0, 0

`endif

//--- fetch_pkg.sv
`default_nettype none

`include "fetch_consts.svh"

package fetch_pkg;

  typedef logic [`FETCH_XLEN-1:0]   addr_t;
  typedef logic [`FETCH_INST_W-1:0] inst_t;
  typedef logic [`FETCH_XLEN-1:0]   word_t;    // one bus beat
  typedef logic [`FETCH_IDX_W-1:0]  line_idx_t;
  typedef logic [`FETCH_TAG_W-1:0]  tag_t;
  typedef logic [$clog2(`FETCH_LINE_BEATS)-1:0] beat_idx_t;

  // single-cycle strobe from execute
  typedef struct packed {
    logic  valid;
    addr_t target;
  } redirect_t;

  typedef struct packed {
    logic  valid;
    logic  fault;
    addr_t pc;
    inst_t inst;
  } fetch_out_t;

  typedef enum logic [2:0] {
    RUN,
    MISS_REQ,
    REFILL,
    DRAIN,     // refill finishing after a redirect
    FAULT
  } fetch_state_e;

endpackage

`default_nettype wire

//--- axi_pkg.sv
`default_nettype none

package axi_pkg;

  import fetch_pkg::*;

  typedef logic [3:0] axi_id_t;
  typedef logic [1:0] axi_resp_t;
  typedef logic [7:0] axi_len_t;     // beats minus one
  typedef logic [2:0] axi_size_t;
  typedef logic [1:0] axi_burst_t;

  // read address channel, master to slave
  typedef struct packed {
    logic       valid;
    addr_t      addr;
    axi_id_t    id;
    axi_len_t   len;
    axi_size_t  size;
    axi_burst_t burst;
  } axi_ar_t;

  // read data channel, slave to master
  typedef struct packed {
    logic      valid;
    axi_id_t   id;
    word_t     data;
    axi_resp_t resp;
    logic      last;
  } axi_r_t;

endpackage

`default_nettype wire

//--- pc_gen.sv
`default_nettype none
`timescale 1ns/1ps

`include "fetch_consts.svh"

module pc_gen
  import fetch_pkg::*;
(
  input  wire       clk,
  input  wire       rst_n,
  input  redirect_t redirect_i,
  input  wire       step_i,
  input  wire       hold_i,
  output addr_t     pc_o
);

  addr_t pc_q;
  addr_t pc_seq;

  assign pc_seq = pc_q + addr_t'(4);   // no prediction, just next word

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pc_q <= `FETCH_RESET_PC;
    end else if (redirect_i.valid) begin
      pc_q <= redirect_i.target;   // redirect wins over everything
    end else if (step_i && !hold_i) begin
      pc_q <= pc_seq;
    end
  end

  assign pc_o = pc_q;

endmodule

`default_nettype wire

//--- icache.sv
`default_nettype none
`timescale 1ns/1ps

`include "fetch_consts.svh"

module icache
  import fetch_pkg::*;
(
  input  wire       clk,
  input  wire       rst_n,
  input  addr_t     pc_i,
  input  wire       beat_we_i,
  input  beat_idx_t beat_idx_i,
  input  word_t     beat_data_i,
  input  wire       refill_done_i,
  input  wire       refill_err_i,
  input  addr_t     refill_addr_i,
  output logic      hit_o,
  output inst_t     inst_o
);

  localparam int BEAT_W   = $clog2(`FETCH_LINE_BEATS);
  localparam int BEAT_LSB = `FETCH_OFS_W - BEAT_W;    // pc bit picking the beat
  localparam int HALF_BIT = BEAT_LSB - 1;             // upper or lower word of a beat

  // line store
  logic [`FETCH_LINES-1:0] valid_q;
  tag_t                    tag_q  [`FETCH_LINES];
  word_t                   data_q [`FETCH_LINES][`FETCH_LINE_BEATS];

  // lookup side
  line_idx_t rd_idx;
  tag_t      rd_tag;
  beat_idx_t rd_beat;
  word_t     rd_word;

  // refill side
  line_idx_t wr_idx;
  tag_t      wr_tag;

  assign rd_idx  = pc_i[`FETCH_OFS_W +: `FETCH_IDX_W];
  assign rd_tag  = pc_i[`FETCH_XLEN-1 -: `FETCH_TAG_W];
  assign rd_beat = pc_i[BEAT_LSB +: BEAT_W];
  assign wr_idx  = refill_addr_i[`FETCH_OFS_W +: `FETCH_IDX_W];
  assign wr_tag  = refill_addr_i[`FETCH_XLEN-1 -: `FETCH_TAG_W];

  always_comb begin
    rd_word = data_q[rd_idx][rd_beat];
    hit_o   = valid_q[rd_idx] && (tag_q[rd_idx] == rd_tag);
    if (pc_i[HALF_BIT]) begin
      inst_o = rd_word[`FETCH_INST_W +: `FETCH_INST_W];
    end else begin
      inst_o = rd_word[0 +: `FETCH_INST_W];
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      valid_q <= '0;
    end else if (refill_done_i) begin
      // a failed burst must not leave old contents looking valid
      valid_q[wr_idx] <= !refill_err_i;
    end
  end

  always_ff @(posedge clk) begin
    if (refill_done_i && !refill_err_i) begin
      tag_q[wr_idx] <= wr_tag;
    end
  end

  // beats land as they arrive
  always_ff @(posedge clk) begin
    if (beat_we_i) begin
      data_q[wr_idx][beat_idx_i] <= beat_data_i;
    end
  end

endmodule

`default_nettype wire

//--- axi_rd_master.sv
`default_nettype none
`timescale 1ns/1ps

`include "fetch_consts.svh"

module axi_rd_master
  import fetch_pkg::*;
  import axi_pkg::*;
(
  input  wire       clk,
  input  wire       rst_n,
  input  wire       refill_req_i,
  input  addr_t     refill_addr_i,
  output axi_ar_t   axi_ar_o,
  input  wire       axi_ar_ready_i,
  input  axi_r_t    axi_r_i,
  output logic      axi_r_ready_o,
  output logic      beat_we_o,
  output beat_idx_t beat_idx_o,
  output word_t     beat_data_o,
  output logic      refill_done_o,
  output logic      refill_err_o
);

  logic      ar_valid_q;
  addr_t     ar_addr_q;
  logic      busy_q;      // a burst is outstanding
  beat_idx_t beat_q;
  logic      err_q;       // sticky over the burst

  logic ar_hs;
  logic r_hs;
  logic bad_beat;

  assign ar_hs    = ar_valid_q && axi_ar_ready_i;
  assign r_hs     = axi_r_i.valid && busy_q;
  assign bad_beat = (axi_r_i.resp != `FETCH_AXI_OKAY) || (axi_r_i.id != `FETCH_AXI_ID);

  always_comb begin
    axi_ar_o.valid = ar_valid_q;
    axi_ar_o.addr  = ar_addr_q;
    axi_ar_o.id    = `FETCH_AXI_ID;
    axi_ar_o.len   = axi_len_t'(`FETCH_LINE_BEATS - 1);
    axi_ar_o.size  = `FETCH_AXI_SIZE;
    axi_ar_o.burst = `FETCH_AXI_INCR;
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      ar_valid_q <= 1'b0;
    end else if (refill_req_i) begin
      ar_valid_q <= 1'b1;
    end else if (ar_hs) begin
      ar_valid_q <= 1'b0;    // held until the slave takes it
    end
  end

  always_ff @(posedge clk) begin
    if (refill_req_i) begin
      ar_addr_q <= {refill_addr_i[`FETCH_XLEN-1:`FETCH_OFS_W], {`FETCH_OFS_W{1'b0}}};
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      busy_q <= 1'b0;
      beat_q <= '0;
      err_q  <= 1'b0;
    end else if (refill_req_i) begin
      busy_q <= 1'b1;
      beat_q <= '0;
      err_q  <= 1'b0;
    end else if (r_hs) begin
      if (axi_r_i.last) begin
        busy_q <= 1'b0;
        beat_q <= '0;
        err_q  <= 1'b0;
      end else begin
        beat_q <= beat_q + beat_idx_t'(1);
        err_q  <= err_q || bad_beat;
      end
    end
  end

  assign axi_r_ready_o = busy_q;   // ready for the whole refill
  assign beat_we_o     = r_hs;
  assign beat_idx_o    = beat_q;
  assign beat_data_o   = axi_r_i.data;
  assign refill_done_o = r_hs && axi_r_i.last;
  assign refill_err_o  = err_q || (r_hs && bad_beat);

endmodule

`default_nettype wire

//--- fetch_ctrl.sv
`default_nettype none
`timescale 1ns/1ps

`include "fetch_consts.svh"

module fetch_ctrl
  import fetch_pkg::*;
(
  input  wire        clk,
  input  wire        rst_n,
  input  redirect_t  redirect_i,
  input  wire        stall_i,
  input  addr_t      pc_i,
  input  wire        hit_i,
  input  inst_t      inst_i,
  input  wire        refill_done_i,
  input  wire        refill_err_i,
  output logic       pc_step_o,
  output logic       pc_hold_o,
  output logic       refill_req_o,
  output addr_t      refill_addr_o,
  output fetch_out_t fetch_o
);

  fetch_state_e state_q, state_d;

  logic  out_valid_q, out_valid_d;
  logic  out_fault_q, out_fault_d;
  addr_t out_pc_q, out_pc_d;
  inst_t out_inst_q, out_inst_d;
  logic  fault_pend_q, fault_pend_d;   // fault word not yet handed out
  addr_t raddr_q;                      // line being refilled, survives redirects

  always_comb begin
    state_d      = state_q;
    out_valid_d  = 1'b0;
    out_fault_d  = 1'b0;
    out_pc_d     = out_pc_q;
    out_inst_d   = out_inst_q;
    fault_pend_d = fault_pend_q;
    pc_step_o    = 1'b0;
    pc_hold_o    = 1'b1;
    refill_req_o = 1'b0;
    unique case (state_q)
      RUN: begin
        if (!redirect_i.valid && !stall_i) begin
          if (hit_i) begin
            out_valid_d = 1'b1;
            out_pc_d    = pc_i;
            out_inst_d  = inst_i;
            pc_step_o   = 1'b1;
            pc_hold_o   = 1'b0;
          end else begin
            state_d = MISS_REQ;
          end
        end
      end
      MISS_REQ: begin
        if (redirect_i.valid) begin
          state_d = RUN;   // drop the miss, nothing sent yet
        end else begin
          refill_req_o = 1'b1;
          state_d      = REFILL;
        end
      end
      REFILL: begin
        if (refill_done_i) begin
          if (redirect_i.valid || !refill_err_i) begin
            state_d = RUN;
          end else begin
            state_d      = FAULT;
            fault_pend_d = 1'b1;
          end
        end else if (redirect_i.valid) begin
          state_d = DRAIN;
        end
      end
      DRAIN: begin
        if (refill_done_i) begin
          state_d = RUN;   // pc already holds the target
        end
      end
      FAULT: begin
        if (redirect_i.valid) begin
          state_d      = RUN;
          fault_pend_d = 1'b0;
        end else if (fault_pend_q && !stall_i) begin
          out_valid_d  = 1'b1;
          out_fault_d  = 1'b1;
          out_pc_d     = pc_i;
          out_inst_d   = `FETCH_NOP;
          fault_pend_d = 1'b0;
        end
      end
      default: state_d = RUN;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q      <= RUN;
      out_valid_q  <= 1'b0;
      out_fault_q  <= 1'b0;
      fault_pend_q <= 1'b0;
    end else begin
      state_q      <= state_d;
      out_valid_q  <= out_valid_d;
      out_fault_q  <= out_fault_d;
      fault_pend_q <= fault_pend_d;
    end
  end

  always_ff @(posedge clk) begin
    out_pc_q   <= out_pc_d;
    out_inst_q <= out_inst_d;
    if (state_q == RUN && state_d == MISS_REQ) begin
      raddr_q <= {pc_i[`FETCH_XLEN-1:`FETCH_OFS_W], {`FETCH_OFS_W{1'b0}}};
    end
  end

  assign refill_addr_o = raddr_q;

  always_comb begin
    fetch_o.valid = out_valid_q;
    fetch_o.fault = out_fault_q;
    fetch_o.pc    = out_pc_q;
    fetch_o.inst  = out_inst_q;
  end

endmodule

`default_nettype wire

//--- if_stage.sv
`default_nettype none
`timescale 1ns/1ps

module if_stage
  import fetch_pkg::*;
  import axi_pkg::*;
(
  input  wire        clk,
  input  wire        rst_n,
  input  redirect_t  redirect_i,
  input  wire        stall_i,
  output fetch_out_t fetch_o,
  output axi_ar_t    axi_ar_o,
  input  wire        axi_ar_ready_i,
  input  axi_r_t     axi_r_i,
  output logic       axi_r_ready_o
);

  addr_t     pc;
  logic      pc_step;
  logic      pc_hold;
  logic      hit;
  inst_t     inst;
  logic      refill_req;
  addr_t     refill_addr;
  logic      beat_we;
  beat_idx_t beat_idx;
  word_t     beat_data;
  logic      refill_done;
  logic      refill_err;

  fetch_ctrl u_fetch_ctrl (
    .clk           (clk),
    .rst_n         (rst_n),
    .redirect_i    (redirect_i),
    .stall_i       (stall_i),
    .pc_i          (pc),
    .hit_i         (hit),
    .inst_i        (inst),
    .refill_done_i (refill_done),
    .refill_err_i  (refill_err),
    .pc_step_o     (pc_step),
    .pc_hold_o     (pc_hold),
    .refill_req_o  (refill_req),
    .refill_addr_o (refill_addr),
    .fetch_o       (fetch_o)
  );

  pc_gen u_pc_gen (
    .clk        (clk),
    .rst_n      (rst_n),
    .redirect_i (redirect_i),   // loaded here directly
    .step_i     (pc_step),
    .hold_i     (pc_hold),
    .pc_o       (pc)
  );

  icache u_icache (
    .clk           (clk),
    .rst_n         (rst_n),
    .pc_i          (pc),
    .beat_we_i     (beat_we),
    .beat_idx_i    (beat_idx),
    .beat_data_i   (beat_data),
    .refill_done_i (refill_done),
    .refill_err_i  (refill_err),
    .refill_addr_i (refill_addr),
    .hit_o         (hit),
    .inst_o        (inst)
  );

  axi_rd_master u_axi_rd_master (
    .clk            (clk),
    .rst_n          (rst_n),
    .refill_req_i   (refill_req),
    .refill_addr_i  (refill_addr),
    .axi_ar_o       (axi_ar_o),
    .axi_ar_ready_i (axi_ar_ready_i),
    .axi_r_i        (axi_r_i),
    .axi_r_ready_o  (axi_r_ready_o),
    .beat_we_o      (beat_we),
    .beat_idx_o     (beat_idx),
    .beat_data_o    (beat_data),
    .refill_done_o  (refill_done),
    .refill_err_o   (refill_err)
  );

endmodule

`default_nettype wire

//--- if_stage_sva.sv
`default_nettype none
`timescale 1ns/1ps

module if_stage_sva
  import fetch_pkg::*;
  import axi_pkg::*;
(
  input wire        clk,
  input wire        rst_n,
  input wire        stall_i,
  input fetch_out_t fetch_o,
  input axi_ar_t    axi_ar_o,
  input wire        axi_ar_ready_i,
  input axi_r_t     axi_r_i,
  input wire        axi_r_ready_o,
  input wire        refill_done_i
);

  logic ar_open_q;   // AR accepted and burst not yet done

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      ar_open_q <= 1'b0;
    end else if (axi_ar_o.valid && axi_ar_ready_i) begin
      ar_open_q <= 1'b1;
    end else if (refill_done_i) begin
      ar_open_q <= 1'b0;
    end
  end

  ar_stable: assert property (@(posedge clk) disable iff (!rst_n)
    axi_ar_o.valid && !axi_ar_ready_i |=> $stable(axi_ar_o))
    else $error("AR payload changed while waiting for ready");

  r_stable: assert property (@(posedge clk) disable iff (!rst_n)
    axi_r_i.valid && !axi_r_ready_o |=> $stable(axi_r_i))
    else $error("R payload changed while waiting for ready");

  one_ar: assert property (@(posedge clk) disable iff (!rst_n)
    axi_ar_o.valid && axi_ar_ready_i |-> !ar_open_q)
    else $error("second AR before the refill completed");

  stall_quiet: assert property (@(posedge clk) disable iff (!rst_n)
    stall_i |=> !fetch_o.valid)
    else $error("fetch output valid right after a stall");

endmodule

bind if_stage if_stage_sva u_if_stage_sva (
  .clk            (clk),
  .rst_n          (rst_n),
  .stall_i        (stall_i),
  .fetch_o        (fetch_o),
  .axi_ar_o       (axi_ar_o),
  .axi_ar_ready_i (axi_ar_ready_i),
  .axi_r_i        (axi_r_i),
  .axi_r_ready_o  (axi_r_ready_o),
  .refill_done_i  (refill_done)
);

`default_nettype wire

//--- tb_if_stage.sv
`default_nettype none
`timescale 1ns/1ps

`include "fetch_consts.svh"

module tb_if_stage
  import fetch_pkg::*;
  import axi_pkg::*;
;

  logic       clk;
  logic       rst_n;
  redirect_t  redirect_i;
  logic       stall_i;
  fetch_out_t fetch_o;
  axi_ar_t    axi_ar_o;
  logic       axi_ar_ready_i;
  axi_r_t     axi_r_i;
  logic       axi_r_ready_o;

  integer seed = 25101;
  logic   stall_en;
  addr_t  exp_pc;       // pc model that steps by 4 and loads on redirect
  logic   halted;       // fault delivered and waiting for a redirect
  integer n_delivered;
  integer n_faults;
  integer ar_count;

  // memory model state
  logic   mem_busy;
  addr_t  mem_addr;
  integer mem_beat;
  integer mem_gap;

  if_stage u_if_stage (
    .clk            (clk),
    .rst_n          (rst_n),
    .redirect_i     (redirect_i),
    .stall_i        (stall_i),
    .fetch_o        (fetch_o),
    .axi_ar_o       (axi_ar_o),
    .axi_ar_ready_i (axi_ar_ready_i),
    .axi_r_i        (axi_r_i),
    .axi_r_ready_o  (axi_r_ready_o)
  );

  always #5 clk = ~clk;

  // instruction word stored at byte address a
  function automatic inst_t expected_inst(input addr_t a);
    logic [31:0] x;
    x = a[31:0] ^ a[63:32];
    return (x * 32'h9e37_79b1) ^ {x[15:0], x[31:16]};
  endfunction

  function automatic logic in_err_window(input addr_t a);
    return (a >= 64'h8000_1000) && (a <= 64'h8000_10ff);
  endfunction

  function automatic axi_r_t make_beat(input addr_t a, input logic last);
    axi_r_t r;
    r.valid = 1'b1;
    r.id    = `FETCH_AXI_ID;
    r.data  = {expected_inst(a + 4), expected_inst(a)};
    r.resp  = in_err_window(a) ? 2'b10 : 2'b00;   // SLVERR inside the window
    r.last  = last;
    return r;
  endfunction

  task automatic report_failure(input string why);
    $display("error at %0t: %s", $time, why);
    $display("TESTS FAILED");
    $fatal(1, "stopping at first error");
  endtask

  task automatic check(input string name, input logic [63:0] got, input logic [63:0] exp);
    if (got !== exp) begin
      $display("mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
      $display("TESTS FAILED");
      $fatal(1, "stopping at first mismatch");
    end
  endtask

  // behavioral AXI slave with random AR and R delays
  always @(posedge clk) begin
    if (!rst_n) begin
      axi_ar_ready_i <= 1'b0;
      axi_r_i        <= '0;
      mem_busy       <= 1'b0;
    end else if (!mem_busy) begin
      if (axi_ar_o.valid && axi_ar_ready_i) begin
        axi_ar_ready_i <= 1'b0;
        mem_busy       <= 1'b1;
        mem_addr       <= axi_ar_o.addr;
        mem_beat       <= 0;
        mem_gap        <= $random(seed) & 3;
      end else if (axi_ar_o.valid) begin
        axi_ar_ready_i <= (($random(seed) & 3) == 0);
      end
    end else if (axi_r_i.valid) begin
      if (axi_r_ready_o) begin
        axi_r_i.valid <= 1'b0;
        mem_beat      <= mem_beat + 1;
        mem_gap       <= $random(seed) & 3;
        if (axi_r_i.last) mem_busy <= 1'b0;
      end
    end else if (mem_gap != 0) begin
      mem_gap <= mem_gap - 1;
    end else begin
      axi_r_i <= make_beat(mem_addr + addr_t'(8 * mem_beat), mem_beat == 1);
    end
  end

  always @(posedge clk) begin
    stall_i <= stall_en && (($random(seed) & 7) == 0);   // random decode holds
  end

  // compare process sampling mid-cycle
  always @(negedge clk) begin
    if (rst_n) begin
      if (fetch_o.valid) begin
        if (halted) report_failure("fetch output appeared while waiting in fault state");
        check("fetch_o.pc", fetch_o.pc, exp_pc);
        if (in_err_window(exp_pc)) begin
          check("fetch_o.fault", fetch_o.fault, 1'b1);
          check("fetch_o.inst", fetch_o.inst, `FETCH_NOP);
          halted   = 1'b1;
          n_faults = n_faults + 1;
        end else begin
          check("fetch_o.fault", fetch_o.fault, 1'b0);
          check("fetch_o.inst", fetch_o.inst, expected_inst(exp_pc));
          exp_pc = exp_pc + 4;
        end
        n_delivered = n_delivered + 1;
      end
      if (redirect_i.valid) begin
        exp_pc = redirect_i.target;
        halted = 1'b0;
      end
      if (axi_ar_o.valid) begin
        // one aligned INCR burst of two 8-byte beats
        check("axi_ar_o.id", axi_ar_o.id, 64'd1);
        check("axi_ar_o.len", axi_ar_o.len, 64'd1);
        check("axi_ar_o.size", axi_ar_o.size, 64'd3);
        check("axi_ar_o.burst", axi_ar_o.burst, 64'd1);
        check("axi_ar_o.addr[3:0]", axi_ar_o.addr[3:0], 64'd0);
        if (axi_ar_ready_i) ar_count = ar_count + 1;
      end
      if (axi_r_i.valid) check("axi_r_ready_o", axi_r_ready_o, 1'b1);
    end
  end

  task automatic send_redirect(input addr_t target);
    @(posedge clk);
    redirect_i <= '{valid: 1'b1, target: target};
    @(posedge clk);
    redirect_i <= '0;
  endtask

  task automatic wait_deliveries(input integer n, input string what);
    integer start;
    integer cyc;
    start = n_delivered;
    cyc   = 0;
    while (n_delivered < start + n) begin
      @(posedge clk);
      cyc = cyc + 1;
      if (cyc > 5000) report_failure({"no fetch output while waiting for ", what});
    end
  endtask

  task automatic wait_fault;
    integer start;
    integer cyc;
    start = n_faults;
    cyc   = 0;
    while (n_faults == start) begin
      @(posedge clk);
      cyc = cyc + 1;
      if (cyc > 2000) report_failure("the fault word never came out of the error window");
    end
  endtask

  task automatic wait_ar_valid;
    integer cyc;
    cyc = 0;
    while (!axi_ar_o.valid) begin
      @(posedge clk);
      cyc = cyc + 1;
      if (cyc > 500) report_failure("no refill read was issued for an uncached line");
    end
  endtask

  initial begin
    integer i;
    integer ar_base;
    clk         = 1'b0;
    rst_n       = 1'b0;
    redirect_i  = '0;
    stall_i     = 1'b0;
    stall_en    = 1'b0;
    axi_ar_ready_i = 1'b0;
    axi_r_i     = '0;
    exp_pc      = `FETCH_RESET_PC;
    halted      = 1'b0;
    n_delivered = 0;
    n_faults    = 0;
    ar_count    = 0;
    repeat (16) @(posedge clk);
    rst_n <= 1'b1;
    @(negedge clk);
    check("fetch_o.valid", fetch_o.valid, 1'b0);
    check("axi_ar_o.valid", axi_ar_o.valid, 1'b0);
    check("axi_r_ready_o", axi_r_ready_o, 1'b0);
    stall_en = 1'b1;

    wait_deliveries(64, "the straight-line run");

    // loop over lines 4..11 that must still be cached
    send_redirect(64'h8000_0040);
    wait_deliveries(1, "the loop target");
    ar_base = ar_count;
    wait_deliveries(31, "the cached loop");
    check("ar handshakes", ar_count, ar_base);

    for (i = 0; i < 12; i = i + 1) begin
      repeat ($random(seed) & 31) @(posedge clk);
      send_redirect(64'h8000_0000 + addr_t'(($random(seed) & 32'h3ff) << 2));
    end
    wait_deliveries(8, "random redirects");

    // redirect while a refill is in flight
    send_redirect(64'h8000_2000);
    wait_ar_valid();
    send_redirect(64'h8000_0040);
    wait_deliveries(8, "the redirect during refill");

    send_redirect(64'h8000_1000);
    wait_fault();
    repeat (40) @(posedge clk);
    send_redirect(64'h8000_0300);
    wait_deliveries(16, "recovery after fault");

    $display("TESTS PASSED");
    $finish;
  end

endmodule

`default_nettype wire

//--- sources.f
+incdir+.
fetch_pkg.sv
axi_pkg.sv
pc_gen.sv
icache.sv
axi_rd_master.sv
fetch_ctrl.sv
if_stage.sv
if_stage_sva.sv
tb_if_stage.sv

//--- Makefile
VERILATOR  ?= verilator
FILELIST   ?= sources.f
TB_TOP     ?= tb_if_stage
RTL_TOP    ?= if_stage
BUILD_DIR  ?= obj_dir
LINT_FLAGS ?= --lint-only
SIM_FLAGS  ?= --binary --timing --assert

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --timing --assert -f $(FILELIST) --top-module $(TB_TOP)

$(BUILD_DIR)/V$(TB_TOP): $(shell grep -v '^+' $(FILELIST)) fetch_consts.svh
	$(VERILATOR) $(SIM_FLAGS) -f $(FILELIST) --top-module $(TB_TOP) --Mdir $(BUILD_DIR)

sim: $(BUILD_DIR)/V$(TB_TOP)
	./$(BUILD_DIR)/V$(TB_TOP)

clean:
	rm -rf $(BUILD_DIR)
